// ==== filelist.f ====
+incdir+rtl
rtl/DesPkg.sv
rtl/DesDecoder.sv
rtl/FIFOTop.sv
rtl/Deserializer.sv
sim/DeserializerTst.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = DeserializerTst
FILELIST  = filelist.f
OBJDIR    = obj_dir
EXE       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Passes only when the pass line shows up in the simulation output.
run: compile
	@out="$$(./$(EXE))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)

// ==== sim/DeserializerTst.sv ====
`timescale 1ns/1ps
`include "Des_cfg.svh"

module DeserializerTst;

  // Frames sent: 8 plain, 3 around a bad one, 10 noisy, 33 to overflow.
  localparam int FrameTotal    = 8 + 3 + 10 + 33;
  localparam int TimeoutCycles = FrameTotal * 60 + 2000;
  localparam int FifoDepth     = 1 << `DES_AWID;

  logic               ParOutClk;
  logic               Reset;
  logic               SerialIn;
  logic               SerValid;
  logic               ReadReq;
  DesPkg::DesWord_t   ParOut;
  logic               ParValid;
  DesPkg::DesStatus_t Status;

  // Expected FIFO contents, oldest first.
  DesPkg::DesWord_t Model[$];
  DesPkg::DesWord_t ExpWord;
  logic             ExpValid;
  logic             CmpArm;
  int               ExpParErr;
  int               ExpOvf;
  int               ParErrCnt;
  int               OvfCnt;

  Deserializer UUT
  (
    .ParOutClk (ParOutClk),
    .Reset     (Reset),
    .SerialIn  (SerialIn),
    .SerValid  (SerValid),
    .ReadReq   (ReadReq),
    .ParOut    (ParOut),
    .ParValid  (ParValid),
    .Status    (Status)
  );

  always #4 ParOutClk = ~ParOutClk;

  // ----------------------------------------------------------------------
  // Reference model and checks.
  // ----------------------------------------------------------------------

  // Even parity bit: makes the total count of ones even.
  function automatic logic FrameWord_f(input DesPkg::DesWord_t Word);
    int Ones;
    begin
      Ones = 0;
      for (int Idx = 0; Idx < `DES_DWID; Idx++)
      begin
        Ones += int'(Word.Data[Idx]);
      end
      return Ones[0];
    end
  endfunction

  // Flags as the model sees them once the line is quiet.
  function automatic DesPkg::DesStatus_t ExpStatus();
    DesPkg::DesStatus_t St;
    begin
      St           = '0;
      St.FIFOEmpty = (Model.size() == 0);
      St.FIFOFull  = (Model.size() == FifoDepth);
      return St;
    end
  endfunction

  // True when noise plus sync only hits the pattern on the last sync bit.
  function automatic bit SyncClean(input logic [15:0] Noise, input int Len);
    logic [`DES_SYNCW-1:0] Hist;
    logic [`DES_SYNCW-1:0] Sync;
    begin
      Hist = '0;
      Sync = `DES_SYNC;
      for (int Idx = Len - 1; Idx >= 0; Idx--)
      begin
        Hist = {Hist[`DES_SYNCW-2:0], Noise[Idx]};
        if (Hist == Sync)
          return 1'b0;
      end
      for (int Idx = `DES_SYNCW - 1; Idx > 0; Idx--)
      begin
        Hist = {Hist[`DES_SYNCW-2:0], Sync[Idx]};
        if (Hist == Sync)
          return 1'b0;
      end
      return 1'b1;
    end
  endfunction

  task automatic FailRun();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first error.");
  endtask

  task automatic CheckWord(input string Name, input DesPkg::DesWord_t Exp,
                           input DesPkg::DesWord_t Act);
    if (Exp !== Act)
    begin
      $display("error: %s expected 0x%08h actual 0x%08h", Name, Exp, Act);
      FailRun();
    end
  endtask

  task automatic CheckBit(input string Name, input logic Exp, input logic Act);
    if (Exp !== Act)
    begin
      $display("error: %s expected 0x%0h actual 0x%0h", Name, Exp, Act);
      FailRun();
    end
  endtask

  task automatic CheckStatus(input DesPkg::DesStatus_t Exp, input DesPkg::DesStatus_t Act);
    if (Exp !== Act)
    begin
      $display("error: Status expected 0x%01h actual 0x%01h", Exp, Act);
      FailRun();
    end
  endtask

  task automatic CheckCount(input string Name, input int Exp, input int Act);
    if (Exp != Act)
    begin
      $display("error: %s expected 0x%0h actual 0x%0h", Name, Exp, Act);
      FailRun();
    end
  endtask

  // Pop decision at the edge, compare half a cycle later.
  always @(posedge ParOutClk)
  begin
    if (Reset)
    begin
      CmpArm   = 1'b0;
      ExpValid = 1'b0;
      ExpWord  = '0;
    end
    else
    begin
      CmpArm   = 1'b1;
      ExpValid = ReadReq && (Model.size() > 0);
      ExpWord  = ExpValid ? Model.pop_front() : '0;
    end
  end

  always @(negedge ParOutClk)
  begin
    if (CmpArm)
    begin
      CheckBit("ParValid", ExpValid, ParValid);
      CheckWord("ParOut", ExpWord, ParOut);
      // Strobes are one cycle wide, so high cycles count pulses.
      ParErrCnt += int'(Status.ParityErr);
      OvfCnt    += int'(Status.Overflow);
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus.
  // ----------------------------------------------------------------------

  // One valid bit, optionally after a few idle cycles of junk.
  task automatic SendBit(input logic Bit, input bit Gaps);
    int Gap;
    begin
      Gap = (Gaps && ($urandom % 4 == 0)) ? int'($urandom % 4) : 0;
      repeat (Gap)
      begin
        @(negedge ParOutClk);
        SerValid = 1'b0;
        SerialIn = 1'($urandom);
      end
      @(negedge ParOutClk);
      SerValid = 1'b1;
      SerialIn = Bit;
    end
  endtask

  task automatic SendFrame(input DesPkg::DesWord_t Word, input bit BadParity, input bit Noisy);
    logic [15:0]           Noise;
    int                    NoiseLen;
    logic [`DES_SYNCW-1:0] Sync;
    begin
      Sync     = `DES_SYNC;
      NoiseLen = Noisy ? int'(1 + $urandom % 12) : 0;
      Noise    = 16'($urandom);
      // Noise must not fake an early sync.
      while (!SyncClean(Noise, NoiseLen))
        Noise = 16'($urandom);
      for (int Idx = NoiseLen - 1; Idx >= 0; Idx--)
        SendBit(Noise[Idx], Noisy);
      for (int Idx = `DES_SYNCW - 1; Idx >= 0; Idx--)
        SendBit(Sync[Idx], Noisy);
      for (int Idx = `DES_DWID - 1; Idx >= 0; Idx--)
        SendBit(Word.Data[Idx], Noisy);
      SendBit(FrameWord_f(Word) ^ BadParity, Noisy);
      @(negedge ParOutClk);
      SerValid = 1'b0;
      SerialIn = 1'b0;
      // Drop rules: bad parity first, then a full FIFO.
      if (BadParity)
        ExpParErr++;
      else if (Model.size() < FifoDepth)
        Model.push_back(Word);
      else
        ExpOvf++;
    end
  endtask

  // Strobes land within four cycles of the parity bit.
  task automatic Settle();
    repeat (6) @(negedge ParOutClk);
    CheckStatus(ExpStatus(), Status);
    CheckCount("ParityErr pulses", ExpParErr, ParErrCnt);
    CheckCount("Overflow pulses", ExpOvf, OvfCnt);
  endtask

  // Random read requests until the model is drained.
  task automatic ReadAll();
    while (Model.size() > 0)
    begin
      @(negedge ParOutClk);
      ReadReq = ($urandom % 4) != 0;
    end
    @(negedge ParOutClk);
    ReadReq = 1'b0;
    Settle();
  endtask

  function automatic DesPkg::DesWord_t RandWord();
    DesPkg::DesWord_t Word;
    begin
      Word.Data = `DES_DWID'($urandom);
      return Word;
    end
  endfunction

  // Watchdog.
  initial
  begin
    #(TimeoutCycles * 8);
    $display("Timeout: the run did not finish in %0d cycles.", TimeoutCycles);
    FailRun();
  end

  initial
  begin
    ParOutClk = 1'b0;
    Reset     = 1'b1;
    SerialIn  = 1'b0;
    SerValid  = 1'b0;
    ReadReq   = 1'b0;
    ExpParErr = 0;
    ExpOvf    = 0;
    ParErrCnt = 0;
    OvfCnt    = 0;
    void'($urandom(32'h23f62015));
    repeat (8) @(posedge ParOutClk);
    @(negedge ParOutClk);
    Reset = 1'b0;

    // Idle flags, then reads against an empty FIFO.
    CheckStatus(ExpStatus(), Status);
    ReadReq = 1'b1;
    repeat (4) @(negedge ParOutClk);
    ReadReq = 1'b0;
    Settle();

    // Clean frames.
    for (int Idx = 0; Idx < 8; Idx++)
      SendFrame(RandWord(), 1'b0, 1'b0);
    Settle();
    ReadAll();

    // Bad parity in the middle.
    SendFrame(RandWord(), 1'b0, 1'b0);
    SendFrame(RandWord(), 1'b1, 1'b0);
    SendFrame(RandWord(), 1'b0, 1'b0);
    Settle();
    ReadAll();

    // Junk before sync and gaps in the line.
    for (int Idx = 0; Idx < 10; Idx++)
      SendFrame(RandWord(), 1'b0, 1'b1);
    Settle();
    ReadAll();

    // One frame past full.
    for (int Idx = 0; Idx < FifoDepth + 1; Idx++)
      SendFrame(RandWord(), 1'b0, 1'b0);
    Settle();
    ReadAll();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rtl/Deserializer.sv ====
`timescale 1ns/1ps
`include "Des_cfg.svh"

module Deserializer
(
  input  logic                ParOutClk,
  input  logic                Reset,
  input  logic                SerialIn,
  input  logic                SerValid,
  input  logic                ReadReq,
  output DesPkg::DesWord_t    ParOut,
  output logic                ParValid,
  output DesPkg::DesStatus_t  Status
);

  // Decoder to FIFO.
  DesPkg::FifoWr_t  DecodeToFifo;
  logic             ParityErr;

  // FIFO read side.
  DesPkg::DesWord_t FifoHead;
  logic             FifoEmpty;
  logic             FifoFull;
  logic             Overflow;
  logic             Pop;

  // Output buffer.
  DesPkg::DesWord_t ParBuf;
  logic             ParValidR;

  // ----------------------------------------------------------------------
  // Output buffer.
  // ----------------------------------------------------------------------

  // Read requests against an empty FIFO are ignored.
  assign Pop = ReadReq && !FifoEmpty;

  // Popped word for one cycle, zero otherwise.
  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      ParBuf    <= '0;
      ParValidR <= 1'b0;
    end
    else
    begin
      ParBuf    <= Pop ? FifoHead : '0;
      ParValidR <= Pop;
    end
  end

  assign ParOut   = ParBuf;
  assign ParValid = ParValidR;

  // Flags to the outside.
  always_comb
  begin
    Status.FIFOEmpty = FifoEmpty;
    Status.FIFOFull  = FifoFull;
    Status.ParityErr = ParityErr;
    Status.Overflow  = Overflow;
  end

  // ----------------------------------------------------------------------
  // Structure.
  // ----------------------------------------------------------------------

  DesDecoder DesDecoderU1
  (
    .ParOutClk (ParOutClk),
    .Reset     (Reset),
    .SerialIn  (SerialIn),
    .SerValid  (SerValid),
    .FifoWr    (DecodeToFifo),
    .ParityErr (ParityErr)
  );

  FIFOTop #(.AWid(`DES_AWID)) FifoU1
  (
    .ParOutClk (ParOutClk),
    .Reset     (Reset),
    .FifoWr    (DecodeToFifo),
    .Pop       (Pop),
    .Head      (FifoHead),
    .Empty     (FifoEmpty),
    .Full      (FifoFull),
    .Overflow  (Overflow)
  );

  // Every valid output word moved the FIFO read pointer one edge before.
  ValidFromPop: assert property (@(posedge ParOutClk) disable iff (Reset)
    ParValid |-> (FifoU1.RdPtr == $past(FifoU1.RdPtr) + 1'b1));

endmodule

// ==== rtl/FIFOTop.sv ====
`timescale 1ns/1ps

module FIFOTop
#(
  parameter int AWid = 5
)
(
  input  logic              ParOutClk,
  input  logic              Reset,
  input  DesPkg::FifoWr_t   FifoWr,
  input  logic              Pop,
  output DesPkg::DesWord_t  Head,
  output logic              Empty,
  output logic              Full,
  output logic              Overflow
);

  localparam int Depth = 2 ** AWid;

  // Storage array.
  DesPkg::DesWord_t Mem [Depth];

  // Pointers carry one extra wrap bit.
  logic [AWid:0] WrPtr;
  logic [AWid:0] RdPtr;

  logic DoWrite;
  logic DoPop;
  logic OverflowR;

  // ----------------------------------------------------------------------
  // Flags and handshakes.
  // ----------------------------------------------------------------------

  // Same address, same wrap bit means nothing is stored.
  assign Empty = (WrPtr == RdPtr);

  // Same address, opposite wrap bit means every entry is in use.
  assign Full = (WrPtr[AWid] != RdPtr[AWid]) &&
                (WrPtr[AWid-1:0] == RdPtr[AWid-1:0]);

  // No back-pressure; a write into a full FIFO is lost.
  assign DoWrite = FifoWr.Write && !Full;
  assign DoPop   = Pop && !Empty;

  // Oldest word is shown ahead.
  assign Head = Mem[RdPtr[AWid-1:0]];

  assign Overflow = OverflowR;

  // ----------------------------------------------------------------------
  // Storage and pointers.
  // ----------------------------------------------------------------------

  always_ff @(posedge ParOutClk)
  begin
    if (DoWrite)
    begin
      Mem[WrPtr[AWid-1:0]] <= FifoWr.Word;
    end
  end

  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      WrPtr     <= '0;
      RdPtr     <= '0;
      OverflowR <= 1'b0;
    end
    else
    begin
      // Write and pop may both happen in one cycle.
      if (DoWrite)
      begin
        WrPtr <= WrPtr + 1'b1;
      end
      if (DoPop)
      begin
        RdPtr <= RdPtr + 1'b1;
      end
      // One-cycle pulse per dropped word.
      OverflowR <= FifoWr.Write && Full;
    end
  end

  // ----------------------------------------------------------------------
  // Checks.
  // ----------------------------------------------------------------------

  // The reader side only pops what is there.
  NoPopEmpty: assert property (@(posedge ParOutClk) disable iff (Reset)
    !(Pop && Empty));

  // Occupancy never passes the depth, which keeps Empty and Full apart.
  OccupancyBound: assert property (@(posedge ParOutClk) disable iff (Reset)
    (AWid+1)'(WrPtr - RdPtr) <= Depth);

endmodule

// ==== rtl/DesDecoder.sv ====
`timescale 1ns/1ps
`include "Des_cfg.svh"

module DesDecoder
(
  input  logic             ParOutClk,
  input  logic             Reset,
  input  logic             SerialIn,
  input  logic             SerValid,
  output DesPkg::FifoWr_t  FifoWr,
  output logic             ParityErr
);

  // Bit counter only needs to count across one payload.
  localparam int CntWid = $clog2(`DES_DWID);

  // Two-flop synchronizer stages.
  logic SerSync1;
  logic SerSync2;
  logic ValSync1;
  logic ValSync2;

  // Decoder state.
  DesPkg::DecState_t      State;
  logic [`DES_SYNCW-1:0]  History;
  logic [`DES_SYNCW-1:0]  HistoryNext;
  logic [CntWid-1:0]      BitCnt;
  logic [`DES_DWID-1:0]   ShiftReg;
  logic                   LastBit;
  logic                   ParityOk;

  // Registered strobes.
  logic WriteR;
  logic ParityErrR;

  // ----------------------------------------------------------------------
  // Input synchronizer.
  // ----------------------------------------------------------------------

  // Data and qualifier travel together so they stay aligned.
  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      SerSync1 <= 1'b0;
      SerSync2 <= 1'b0;
      ValSync1 <= 1'b0;
      ValSync2 <= 1'b0;
    end
    else
    begin
      SerSync1 <= SerialIn;
      SerSync2 <= SerSync1;
      ValSync1 <= SerValid;
      ValSync2 <= ValSync1;
    end
  end

  // ----------------------------------------------------------------------
  // Frame decoder.
  // ----------------------------------------------------------------------

  // History with the incoming bit shifted in, MSB first.
  assign HistoryNext = {History[`DES_SYNCW-2:0], SerSync2};

  // Last payload bit of the frame.
  assign LastBit = (BitCnt == CntWid'(`DES_DWID - 1));

  // Even parity: data ones plus parity bit give an even count.
  assign ParityOk = ~(^ShiftReg ^ SerSync2);

  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      State      <= DesPkg::Hunt;
      History    <= '0;
      BitCnt     <= '0;
      ShiftReg   <= '0;
      WriteR     <= 1'b0;
      ParityErrR <= 1'b0;
    end
    else
    begin
      // Strobes last one cycle.
      WriteR     <= 1'b0;
      ParityErrR <= 1'b0;
      // Nothing moves on a gap in the bit stream.
      if (ValSync2)
      begin
        unique case (State)
          DesPkg::Hunt:
          begin
            if (HistoryNext == `DES_SYNC)
            begin
              // Sync found; fresh history for the next hunt.
              State   <= DesPkg::Payload;
              History <= '0;
              BitCnt  <= '0;
            end
            else
            begin
              History <= HistoryNext;
            end
          end
          DesPkg::Payload:
          begin
            ShiftReg <= {ShiftReg[`DES_DWID-2:0], SerSync2};
            BitCnt   <= BitCnt + 1'b1;
            if (LastBit)
            begin
              State <= DesPkg::Parity;
            end
          end
          DesPkg::Parity:
          begin
            // Good frame goes to the FIFO, bad frame is dropped.
            if (ParityOk)
            begin
              WriteR <= 1'b1;
            end
            else
            begin
              ParityErrR <= 1'b1;
            end
            State <= DesPkg::Hunt;
          end
          default:
          begin
            State <= DesPkg::Hunt;
          end
        endcase
      end
    end
  end

  // Word holds still from the parity bit until the next payload.
  always_comb
  begin
    FifoWr.Write     = WriteR;
    FifoWr.Word.Data = ShiftReg;
  end

  assign ParityErr = ParityErrR;

  // ----------------------------------------------------------------------
  // Checks.
  // ----------------------------------------------------------------------

  // A frame is either written or flagged, never both.
  WrErrExclusive: assert property (@(posedge ParOutClk) disable iff (Reset)
    !(FifoWr.Write && ParityErr));

  // FSM stays inside its encoded states.
  StateLegal: assert property (@(posedge ParOutClk) disable iff (Reset)
    State inside {DesPkg::Hunt, DesPkg::Payload, DesPkg::Parity});

endmodule

// ==== rtl/DesPkg.sv ====
`include "Des_cfg.svh"

package DesPkg;

  // ----------------------------------------------------------------------
  // Decoder FSM states.
  // ----------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    Hunt    = 2'd0,
    Payload = 2'd1,
    Parity  = 2'd2
  } DecState_t;

  // One parallel data word.
  typedef struct packed
  {
    logic [`DES_DWID-1:0] Data;
  } DesWord_t;

  // Decoder to FIFO write port; Word is valid while Write is high.
  typedef struct packed
  {
    logic     Write;
    DesWord_t Word;
  } FifoWr_t;

  // Flags exported at the top level.
  typedef struct packed
  {
    logic FIFOEmpty;
    logic FIFOFull;
    logic ParityErr;
    logic Overflow;
  } DesStatus_t;

endpackage

// ==== rtl/Des_cfg.svh ====
`ifndef DES_CFG_SVH
`define DES_CFG_SVH

// ----------------------------------------------------------------------
// Deserializer build constants.
// ----------------------------------------------------------------------

// Width of one parallel word on every datapath.
`define DES_DWID 32

// FIFO address width; depth is 2**DES_AWID entries.
`define DES_AWID 5

// Sync pattern that opens each frame on the serial line.
`define DES_SYNCW 8
`define DES_SYNC 8'hA5

`endif
